// File: common/exec_pkg.sv
/* execute stage shared types */

package exec_pkg;

    localparam int NUM_LANES = 4;
    localparam int NUM_WARPS = 4;
    localparam int WID_BITS  = $clog2(NUM_WARPS);
    localparam int LANE_BITS = $clog2(NUM_LANES);
    localparam int XLEN      = 32;
    localparam int RD_BITS   = 5;
    localparam int PC_BITS   = 32;

    // one word per thread of the warp
    typedef logic [NUM_LANES-1:0][XLEN-1:0] lane_data_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7,
        ALU_LUI = 4'd8
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_BEQ    = 4'd0,
        BR_BNE    = 4'd1,
        BR_BLT    = 4'd2,
        BR_BGE    = 4'd3,
        BR_JAL    = 4'd4,
        BR_EBREAK = 4'd5,
        BR_ECALL  = 4'd6
    } br_op_e;

    // the same op word reads as an ALU or a branch op, selected by is_branch
    typedef union packed {
        alu_op_e alu;
        br_op_e  br;
    } op_u;

    typedef enum logic {
        LSU_LW = 1'b0,
        LSU_SW = 1'b1
    } lsu_op_e;

    typedef enum logic [1:0] {
        SFU_TMC = 2'd0,
        SFU_TID = 2'd1,
        SFU_WID = 2'd2
    } sfu_op_e;

    typedef struct packed {
        logic [WID_BITS-1:0]  wid;
        logic [NUM_LANES-1:0] tmask;
        logic [PC_BITS-1:0]   pc;
        op_u                  op;
        logic                 is_branch;
        lsu_op_e              lsu_op;
        sfu_op_e              sfu_op;
        logic [RD_BITS-1:0]   rd;
        lane_data_t           rs1_data;
        lane_data_t           rs2_data;
        logic [XLEN-1:0]      imm;
    } dispatch_t;

    typedef struct packed {
        logic [WID_BITS-1:0]  wid;
        logic [NUM_LANES-1:0] tmask;
        logic [PC_BITS-1:0]   pc;
        logic [RD_BITS-1:0]   rd;
        logic                 wb;
        lane_data_t           data;
    } commit_t;

    typedef struct packed {
        logic [WID_BITS-1:0] wid;
        logic                taken;
        logic [PC_BITS-1:0]  dest;
    } branch_ctl_t;

    typedef struct packed {
        logic [WID_BITS-1:0]  wid;
        logic                 tmc_valid;
        logic [NUM_LANES-1:0] tmask;
    } warp_ctl_t;

    typedef struct packed {
        logic                 rw;
        logic [NUM_LANES-1:0] mask;
        lane_data_t           addr;
        lane_data_t           data;
    } mem_req_t;

    typedef struct packed {
        lane_data_t data;
    } mem_rsp_t;

endpackage

// File: alu/alu_unit.sv
/* two-stage lane-parallel integer ALU */

`timescale 1ns/1ps

module alu_unit import exec_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        dispatch_valid,
    output logic        dispatch_ready,
    input  dispatch_t   dispatch,
    output logic        commit_valid,
    input  logic        commit_ready,
    output commit_t     commit,
    output logic        branch_ctl_valid,
    output branch_ctl_t branch_ctl
);

    logic                 s1_valid;
    logic                 s1_ready;
    logic                 s2_ready;
    commit_t              s1_next;
    commit_t              s1_commit;
    logic                 s1_is_br;
    logic                 s1_taken;
    logic [XLEN-1:0]      s1_imm;
    logic                 s2_is_br;
    logic [NUM_LANES-1:0] lane_cmp;
    logic [LANE_BITS-1:0] lead;

    function automatic logic [XLEN-1:0] alu_calc(alu_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b, logic [XLEN-1:0] imm);
        logic [XLEN-1:0] res;
        case (op)
            ALU_ADD: res = a + b;
            ALU_SUB: res = a - b;
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_SLL: res = a << b[4:0];
            ALU_SRL: res = a >> b[4:0];
            ALU_SLT: res = XLEN'($signed(a) < $signed(b));
            ALU_LUI: res = imm;
            default: res = '0;
        endcase
        return res;
    endfunction

    // jal is always taken, ebreak and ecall never are
    function automatic logic br_cmp(br_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        logic res;
        case (op)
            BR_BEQ:  res = (a == b);
            BR_BNE:  res = (a != b);
            BR_BLT:  res = ($signed(a) < $signed(b));
            BR_BGE:  res = ($signed(a) >= $signed(b));
            BR_JAL:  res = 1'b1;
            default: res = 1'b0;
        endcase
        return res;
    endfunction

    // each stage moves when the one after it has room
    assign s2_ready       = !commit_valid || commit_ready;
    assign s1_ready       = !s1_valid || s2_ready;
    assign dispatch_ready = s1_ready;

    // the branch decision follows the lowest active thread
    always_comb begin
        lead = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (dispatch.tmask[i]) begin
                lead = LANE_BITS'(i);
            end
        end
    end

    always_comb begin
        s1_next       = '0;
        s1_next.wid   = dispatch.wid;
        s1_next.tmask = dispatch.tmask;
        s1_next.pc    = dispatch.pc;
        s1_next.rd    = dispatch.rd;
        for (int i = 0; i < NUM_LANES; i++) begin
            lane_cmp[i] = br_cmp(dispatch.op.br, dispatch.rs1_data[i], dispatch.rs2_data[i]);
            if (!dispatch.is_branch) begin
                s1_next.data[i] = alu_calc(dispatch.op.alu, dispatch.rs1_data[i],
                                           dispatch.rs2_data[i], dispatch.imm);
            end else if (dispatch.op.br == BR_JAL) begin
                s1_next.data[i] = XLEN'(dispatch.pc) + XLEN'(4);
            end else begin
                s1_next.data[i] = XLEN'(lane_cmp[i]);
            end
        end
        s1_next.wb = !dispatch.is_branch || !(dispatch.op.br inside {BR_EBREAK, BR_ECALL});
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid     <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            if (s1_ready) begin
                s1_valid <= dispatch_valid;
            end
            if (s2_ready) begin
                commit_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid && s1_ready) begin
            s1_commit <= s1_next;
            s1_is_br  <= dispatch.is_branch;
            s1_taken  <= dispatch.is_branch && lane_cmp[lead];
            s1_imm    <= dispatch.imm;
        end
        if (s1_valid && s2_ready) begin
            commit           <= s1_commit;
            s2_is_br         <= s1_is_br;
            branch_ctl.wid   <= s1_commit.wid;
            branch_ctl.taken <= s1_taken;
            branch_ctl.dest  <= s1_commit.pc + PC_BITS'(s1_imm);
        end
    end

    assign branch_ctl_valid = commit_valid && commit_ready && s2_is_br;

endmodule

// File: lsu/lsu_unit.sv
/* load/store unit, one request in flight */

`timescale 1ns/1ps

module lsu_unit import exec_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      dispatch_valid,
    output logic      dispatch_ready,
    input  dispatch_t dispatch,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output mem_req_t  mem_req,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,
    input  mem_rsp_t  mem_rsp,
    output logic      commit_valid,
    input  logic      commit_ready,
    output commit_t   commit
);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_REQ    = 2'd1,
        ST_WAIT   = 2'd2,
        ST_COMMIT = 2'd3
    } state_e;

    state_e   state;
    state_e   state_next;
    mem_req_t req_q;
    commit_t  commit_q;

    assign dispatch_ready = (state == ST_IDLE);
    assign mem_req_valid  = (state == ST_REQ);
    assign mem_rsp_ready  = (state == ST_WAIT);
    assign commit_valid   = (state == ST_COMMIT);
    assign mem_req        = req_q;
    assign commit         = commit_q;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (dispatch_valid) begin
                    state_next = ST_REQ;
                end
            end
            ST_REQ: begin
                // a store is done once memory takes it
                if (mem_req_ready) begin
                    state_next = req_q.rw ? ST_COMMIT : ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (mem_rsp_valid) begin
                    state_next = ST_COMMIT;
                end
            end
            ST_COMMIT: begin
                if (commit_ready) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid && dispatch_ready) begin
            req_q.rw       <= (dispatch.lsu_op == LSU_SW);
            req_q.mask     <= dispatch.tmask;
            req_q.data     <= dispatch.rs2_data;
            commit_q.wid   <= dispatch.wid;
            commit_q.tmask <= dispatch.tmask;
            commit_q.pc    <= dispatch.pc;
            commit_q.rd    <= dispatch.rd;
            commit_q.wb    <= (dispatch.lsu_op == LSU_LW);
            commit_q.data  <= '0;
            // inactive threads send a zero address
            for (int i = 0; i < NUM_LANES; i++) begin
                req_q.addr[i] <= dispatch.tmask[i] ? dispatch.rs1_data[i] + dispatch.imm : '0;
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                commit_q.data[i] <= req_q.mask[i] ? mem_rsp.data[i] : '0;
            end
        end
    end

endmodule

// File: logic/sfu_unit.sv
/* thread mask control and identity reads */

`timescale 1ns/1ps

module sfu_unit import exec_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      dispatch_valid,
    output logic      dispatch_ready,
    input  dispatch_t dispatch,
    output logic      commit_valid,
    input  logic      commit_ready,
    output commit_t   commit,
    output logic      warp_ctl_valid,
    output warp_ctl_t warp_ctl
);

    commit_t   commit_next;
    warp_ctl_t warp_next;

    assign dispatch_ready = !commit_valid || commit_ready;

    always_comb begin
        commit_next       = '0;
        commit_next.wid   = dispatch.wid;
        commit_next.tmask = dispatch.tmask;
        commit_next.pc    = dispatch.pc;
        commit_next.rd    = dispatch.rd;
        commit_next.wb    = (dispatch.sfu_op != SFU_TMC);
        for (int i = 0; i < NUM_LANES; i++) begin
            case (dispatch.sfu_op)
                SFU_TID: commit_next.data[i] = XLEN'(i);
                SFU_WID: commit_next.data[i] = XLEN'(dispatch.wid);
                default: commit_next.data[i] = '0;
            endcase
        end

        // the new mask sits in the low bits of thread 0's operand
        warp_next.wid       = dispatch.wid;
        warp_next.tmc_valid = (dispatch.sfu_op == SFU_TMC);
        warp_next.tmask     = dispatch.rs1_data[0][NUM_LANES-1:0];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
        end else if (dispatch_ready) begin
            commit_valid <= dispatch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid && dispatch_ready) begin
            commit   <= commit_next;
            warp_ctl <= warp_next;
        end
    end

    // the mask update takes effect together with its commit
    assign warp_ctl_valid = commit_valid && commit_ready && warp_ctl.tmc_valid;

endmodule

// File: logic/execute.sv
/* SIMT execute stage */

`timescale 1ns/1ps

module execute import exec_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        alu_dispatch_valid,
    output logic        alu_dispatch_ready,
    input  dispatch_t   alu_dispatch,
    input  logic        lsu_dispatch_valid,
    output logic        lsu_dispatch_ready,
    input  dispatch_t   lsu_dispatch,
    input  logic        sfu_dispatch_valid,
    output logic        sfu_dispatch_ready,
    input  dispatch_t   sfu_dispatch,

    output logic        alu_commit_valid,
    input  logic        alu_commit_ready,
    output commit_t     alu_commit,
    output logic        lsu_commit_valid,
    input  logic        lsu_commit_ready,
    output commit_t     lsu_commit,
    output logic        sfu_commit_valid,
    input  logic        sfu_commit_ready,
    output commit_t     sfu_commit,

    output logic        mem_req_valid,
    input  logic        mem_req_ready,
    output mem_req_t    mem_req,
    input  logic        mem_rsp_valid,
    output logic        mem_rsp_ready,
    input  mem_rsp_t    mem_rsp,

    output logic        branch_ctl_valid,
    output branch_ctl_t branch_ctl,
    output logic        warp_ctl_valid,
    output warp_ctl_t   warp_ctl,

    output logic        branch_flush,
    output logic        sim_ebreak
);

    alu_unit alu_unit_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .dispatch_valid   (alu_dispatch_valid),
        .dispatch_ready   (alu_dispatch_ready),
        .dispatch         (alu_dispatch),
        .commit_valid     (alu_commit_valid),
        .commit_ready     (alu_commit_ready),
        .commit           (alu_commit),
        .branch_ctl_valid (branch_ctl_valid),
        .branch_ctl       (branch_ctl)
    );

    lsu_unit lsu_unit_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (lsu_dispatch_valid),
        .dispatch_ready (lsu_dispatch_ready),
        .dispatch       (lsu_dispatch),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req        (mem_req),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_ready  (mem_rsp_ready),
        .mem_rsp        (mem_rsp),
        .commit_valid   (lsu_commit_valid),
        .commit_ready   (lsu_commit_ready),
        .commit         (lsu_commit)
    );

    sfu_unit sfu_unit_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .dispatch_valid (sfu_dispatch_valid),
        .dispatch_ready (sfu_dispatch_ready),
        .dispatch       (sfu_dispatch),
        .commit_valid   (sfu_commit_valid),
        .commit_ready   (sfu_commit_ready),
        .commit         (sfu_commit),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl       (warp_ctl)
    );

    // flush on a taken branch, or when a warp masks off all of its threads
    assign branch_flush = (branch_ctl_valid && branch_ctl.taken)
                       || (warp_ctl_valid && warp_ctl.tmc_valid && !(|warp_ctl.tmask));

    // warp 0 reaching ebreak or ecall ends the simulated program
    assign sim_ebreak = alu_dispatch_valid && alu_dispatch_ready
                     && (alu_dispatch.wid == '0)
                     && alu_dispatch.is_branch
                     && (alu_dispatch.op.br inside {BR_EBREAK, BR_ECALL});

endmodule

// File: bench/execute_tests.svh
/* directed tests */

`ifndef EXECUTE_TESTS_SVH
`define EXECUTE_TESTS_SVH

function automatic logic [XLEN-1:0] fill_word(logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, 8'hc3};
endfunction

function automatic logic [XLEN-1:0] model_alu(alu_op_e op, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b, logic [XLEN-1:0] imm);
    if (op == ALU_ADD) return a + b;
    if (op == ALU_SUB) return a - b;
    if (op == ALU_AND) return a & b;
    if (op == ALU_OR) return a | b;
    if (op == ALU_XOR) return a ^ b;
    if (op == ALU_SLL) return a << b[4:0];
    if (op == ALU_SRL) return a >> b[4:0];
    if (op == ALU_SLT) return {31'b0, $signed(a) < $signed(b)};
    return imm;
endfunction

function automatic logic model_taken(br_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    if (op == BR_BEQ) return a == b;
    if (op == BR_BNE) return a != b;
    if (op == BR_BLT) return $signed(a) < $signed(b);
    if (op == BR_BGE) return $signed(a) >= $signed(b);
    return op == BR_JAL;
endfunction

function automatic dispatch_t random_dispatch(logic [NUM_LANES-1:0] tmask);
    dispatch_t d;
    d       = '0;
    d.tmask = tmask;
    d.pc    = {32'($random(seed)) & 32'h0000_fffc};
    d.imm   = 32'($random(seed)) & 32'h0000_0ffc;
    d.rd    = 5'($random(seed));
    for (int i = 0; i < NUM_LANES; i++) begin
        d.rs1_data[i] = $random(seed);
        d.rs2_data[i] = $random(seed);
    end
    return d;
endfunction

task automatic check_val(string what, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
    assert (expected === actual) else begin
        $display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
        error_count++;
    end
endtask

task automatic start_test(string name);
    test_name    = name;
    start_errors = error_count;
endtask

task automatic finish_test();
    if (error_count == start_errors) begin
        tests_passed++;
        $display("%s: ok", test_name);
    end else begin
        tests_failed++;
        $display("%s: failed with %0d errors", test_name, error_count - start_errors);
    end
endtask

// unit 0 is the ALU, 1 the LSU, 2 the SFU; called and left at a falling edge
task automatic issue(int unit, dispatch_t d);
    logic ready;
    case (unit)
        0: begin
            alu_dispatch       = d;
            alu_dispatch_valid = 1'b1;
        end
        1: begin
            lsu_dispatch       = d;
            lsu_dispatch_valid = 1'b1;
        end
        default: begin
            sfu_dispatch       = d;
            sfu_dispatch_valid = 1'b1;
        end
    endcase
    forever begin
        #1;
        ready = (unit == 0) ? alu_dispatch_ready :
                (unit == 1) ? lsu_dispatch_ready : sfu_dispatch_ready;
        stop_seen = sim_ebreak;
        @(negedge clk);
        if (ready) break;
    end
    alu_dispatch_valid = 1'b0;
    lsu_dispatch_valid = 1'b0;
    sfu_dispatch_valid = 1'b0;
endtask

task automatic collect_commit(int unit, output commit_t c);
    logic valid;
    forever begin
        #1;
        valid = (unit == 0) ? alu_commit_valid :
                (unit == 1) ? lsu_commit_valid : sfu_commit_valid;
        c = (unit == 0) ? alu_commit : (unit == 1) ? lsu_commit : sfu_commit;
        bctl_seen_v = branch_ctl_valid;
        bctl_seen   = branch_ctl;
        wctl_seen_v = warp_ctl_valid;
        wctl_seen   = warp_ctl;
        flush_seen  = branch_flush;
        @(negedge clk);
        if (valid) break;
    end
endtask

task automatic test_alu_arith();
    dispatch_t d;
    commit_t   c;
    alu_op_e   op;
    start_test("alu_arith");
    for (int k = 0; k <= 8; k++) begin
        op          = alu_op_e'(k[3:0]);
        d           = random_dispatch(4'b1011);
        d.op.alu    = op;
        d.rd        = 5'(k + 1);
        issue(0, d);
        collect_commit(0, c);
        for (int i = 0; i < NUM_LANES; i++) begin
            if (d.tmask[i]) begin
                check_val(op.name(), model_alu(op, d.rs1_data[i], d.rs2_data[i], d.imm),
                          c.data[i]);
            end
        end
        check_val("tmask", 32'(d.tmask), 32'(c.tmask));
        check_val("rd", 32'(d.rd), 32'(c.rd));
        check_val("wb", 32'd1, 32'(c.wb));
        check_val("branch_ctl_valid", 32'd0, 32'(bctl_seen_v));
    end
    finish_test();
endtask

task automatic run_branch(br_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    dispatch_t d;
    commit_t   c;
    logic      taken;
    // lane 1 is the lowest active thread and decides the branch
    d             = random_dispatch(4'b0110);
    d.is_branch   = 1'b1;
    d.op.br       = op;
    d.rs1_data[1] = a;
    d.rs2_data[1] = b;
    taken         = model_taken(op, a, b);
    issue(0, d);
    collect_commit(0, c);
    check_val({op.name(), " branch_ctl_valid"}, 32'd1, 32'(bctl_seen_v));
    check_val({op.name(), " taken"}, 32'(taken), 32'(bctl_seen.taken));
    check_val({op.name(), " dest"}, d.pc + d.imm, bctl_seen.dest);
    check_val({op.name(), " flush"}, 32'(taken), 32'(flush_seen));
    check_val({op.name(), " rd data"}, (op == BR_JAL) ? d.pc + 32'd4 : 32'(taken),
              c.data[1]);
endtask

task automatic test_branches();
    start_test("branches");
    run_branch(BR_BEQ, 32'd5, 32'd5);
    run_branch(BR_BEQ, 32'd5, 32'd6);
    run_branch(BR_BNE, 32'd7, 32'd7);
    run_branch(BR_BNE, 32'd1, 32'd2);
    run_branch(BR_BLT, 32'hffff_fffd, 32'd2);
    run_branch(BR_BLT, 32'd4, 32'd2);
    run_branch(BR_BGE, 32'd2, 32'd2);
    run_branch(BR_BGE, 32'hffff_ffff, 32'd0);
    run_branch(BR_JAL, 32'd0, 32'd9);
    finish_test();
endtask

task automatic test_alu_pipeline();
    dispatch_t d [4];
    dispatch_t one;
    commit_t   c;
    int        idx;
    int        got;
    int        latency;
    start_test("alu_pipeline");
    for (int k = 0; k < 4; k++) begin
        d[k]    = random_dispatch(4'b1111);
        d[k].rd = 5'(k + 10);
    end
    alu_commit_ready   = 1'b0;
    alu_dispatch       = d[0];
    alu_dispatch_valid = 1'b1;
    idx                = 0;
    repeat (6) begin
        #1;
        if (alu_dispatch_ready) idx++;
        @(negedge clk);
        alu_dispatch = d[idx];
    end
    check_val("accepted while stalled", 32'd2, 32'(idx));
    alu_commit_ready = 1'b1;
    got              = 0;
    while (got < 4) begin
        #1;
        if (alu_commit_valid) begin
            check_val("commit order rd", 32'(got + 10), 32'(alu_commit.rd));
            for (int i = 0; i < NUM_LANES; i++) begin
                check_val("lane sum", d[got].rs1_data[i] + d[got].rs2_data[i],
                          alu_commit.data[i]);
            end
            got++;
        end
        if (alu_dispatch_valid && alu_dispatch_ready) idx++;
        @(negedge clk);
        if (idx < 4) alu_dispatch = d[idx];
        else alu_dispatch_valid = 1'b0;
    end
    // with no stall the commit shows up two cycles after the dispatch
    one                = random_dispatch(4'b1111);
    alu_dispatch       = one;
    alu_dispatch_valid = 1'b1;
    @(negedge clk);
    alu_dispatch_valid = 1'b0;
    latency            = 1;
    #1;
    while (!alu_commit_valid) begin
        @(negedge clk);
        latency++;
        #1;
    end
    check_val("commit latency", 32'd2, 32'(latency));
    collect_commit(0, c);
    finish_test();
endtask

task automatic test_load_store();
    dispatch_t  d;
    commit_t    c;
    logic [7:0] idx;
    start_test("load_store");
    d        = random_dispatch(4'b0101);
    d.lsu_op = LSU_SW;
    d.imm    = 32'h4;
    for (int i = 0; i < NUM_LANES; i++) begin
        d.rs1_data[i] = 32'h100 + 32'(i) * 32'h10;
    end
    issue(1, d);
    collect_commit(1, c);
    check_val("store wb", 32'd0, 32'(c.wb));
    for (int i = 0; i < NUM_LANES; i++) begin
        idx = 8'((d.rs1_data[i] + d.imm) >> 2);
        check_val("memory word", d.tmask[i] ? d.rs2_data[i] : fill_word(idx), mem[idx]);
    end
    d.lsu_op = LSU_LW;
    issue(1, d);
    collect_commit(1, c);
    check_val("load wb", 32'd1, 32'(c.wb));
    check_val("load rd", 32'(d.rd), 32'(c.rd));
    for (int i = 0; i < NUM_LANES; i++) begin
        if (d.tmask[i]) check_val("load data", d.rs2_data[i], c.data[i]);
    end
    finish_test();
endtask

task automatic test_sfu();
    dispatch_t d;
    commit_t   c;
    start_test("sfu");
    d        = random_dispatch(4'b1111);
    d.sfu_op = SFU_TID;
    issue(2, d);
    collect_commit(2, c);
    check_val("tid wb", 32'd1, 32'(c.wb));
    for (int i = 0; i < NUM_LANES; i++) check_val("thread id", 32'(i), c.data[i]);
    d.sfu_op = SFU_WID;
    d.wid    = 2'd2;
    issue(2, d);
    collect_commit(2, c);
    for (int i = 0; i < NUM_LANES; i++) check_val("warp id", 32'd2, c.data[i]);
    d.sfu_op      = SFU_TMC;
    d.rs1_data[0] = 32'h3;
    issue(2, d);
    collect_commit(2, c);
    check_val("tmc wb", 32'd0, 32'(c.wb));
    check_val("warp_ctl_valid", 32'd1, 32'(wctl_seen_v));
    check_val("tmc mask", 32'h3, 32'(wctl_seen.tmask));
    check_val("tmc flush", 32'd0, 32'(flush_seen));
    d.rs1_data[0] = 32'h10;
    issue(2, d);
    collect_commit(2, c);
    check_val("zero tmc warp_ctl_valid", 32'd1, 32'(wctl_seen_v));
    check_val("zero tmc flush", 32'd1, 32'(flush_seen));
    finish_test();
endtask

task automatic run_stop(logic [WID_BITS-1:0] wid, br_op_e op, logic expected);
    dispatch_t d;
    commit_t   c;
    d           = random_dispatch(4'b1111);
    d.wid       = wid;
    d.is_branch = 1'b1;
    d.op.br     = op;
    issue(0, d);
    check_val({op.name(), " sim_ebreak"}, 32'(expected), 32'(stop_seen));
    collect_commit(0, c);
    check_val({op.name(), " wb"}, 32'(op == BR_BEQ), 32'(c.wb));
endtask

task automatic test_sim_stop();
    start_test("sim_stop");
    run_stop(2'd0, BR_EBREAK, 1'b1);
    run_stop(2'd0, BR_ECALL, 1'b1);
    run_stop(2'd1, BR_EBREAK, 1'b0);
    run_stop(2'd1, BR_ECALL, 1'b0);
    run_stop(2'd0, BR_BEQ, 1'b0);
    finish_test();
endtask

`endif

// File: bench/execute_tb.sv
/* execute stage testbench */

`timescale 1ns/1ps

module execute_tb import exec_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        alu_dispatch_valid;
    logic        alu_dispatch_ready;
    dispatch_t   alu_dispatch;
    logic        lsu_dispatch_valid;
    logic        lsu_dispatch_ready;
    dispatch_t   lsu_dispatch;
    logic        sfu_dispatch_valid;
    logic        sfu_dispatch_ready;
    dispatch_t   sfu_dispatch;
    logic        alu_commit_valid;
    logic        alu_commit_ready;
    commit_t     alu_commit;
    logic        lsu_commit_valid;
    logic        lsu_commit_ready;
    commit_t     lsu_commit;
    logic        sfu_commit_valid;
    logic        sfu_commit_ready;
    commit_t     sfu_commit;
    logic        mem_req_valid;
    logic        mem_req_ready;
    mem_req_t    mem_req;
    logic        mem_rsp_valid;
    logic        mem_rsp_ready;
    mem_rsp_t    mem_rsp;
    logic        branch_ctl_valid;
    branch_ctl_t branch_ctl;
    logic        warp_ctl_valid;
    warp_ctl_t   warp_ctl;
    logic        branch_flush;
    logic        sim_ebreak;

    logic [XLEN-1:0] mem [0:255];
    logic [31:0]     seed;
    logic [31:0]     rand_word;
    int              rsp_delay = 0;
    int              cycle_count = 0;
    int              error_count = 0;
    int              start_errors;
    int              tests_passed = 0;
    int              tests_failed = 0;
    string           test_name;

    // what the last collected commit cycle showed on the side outputs
    logic            bctl_seen_v;
    branch_ctl_t     bctl_seen;
    logic            wctl_seen_v;
    warp_ctl_t       wctl_seen;
    logic            flush_seen;
    logic            stop_seen;

    execute execute_inst (.*);

    always #20 clk = ~clk;

    // memory answers loads after 1 to 4 cycles, stores are written when taken
    always @(negedge clk) begin
        mem_rsp_valid = 1'b0;
        if (rsp_delay != 0) begin
            rsp_delay = rsp_delay - 1;
            if (rsp_delay == 0) begin
                mem_rsp_valid = 1'b1;
                // the response is lost unless the LSU waits for it
                assert (mem_rsp_ready) else begin
                    $display("memory response came while the LSU was not ready for it");
                    error_count++;
                end
            end
        end else if (arst_n && mem_req_valid && mem_req_ready) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (mem_req.rw && mem_req.mask[i]) begin
                    mem[mem_req.addr[i][9:2]] = mem_req.data[i];
                end
                mem_rsp.data[i] = mem[mem_req.addr[i][9:2]];
            end
            if (!mem_req.rw) begin
                rand_word = $random(seed);
                rsp_delay = 1 + int'(rand_word[1:0]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    `include "execute_tests.svh"

    initial begin
        seed               = 32'h58ad;
        arst_n             = 1'b0;
        alu_dispatch_valid = 1'b0;
        lsu_dispatch_valid = 1'b0;
        sfu_dispatch_valid = 1'b0;
        alu_dispatch       = '0;
        lsu_dispatch       = '0;
        sfu_dispatch       = '0;
        alu_commit_ready   = 1'b1;
        lsu_commit_ready   = 1'b1;
        sfu_commit_ready   = 1'b1;
        mem_req_ready      = 1'b1;
        mem_rsp_valid      = 1'b0;
        mem_rsp            = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(8'(i));
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        assert (!alu_commit_valid && !lsu_commit_valid && !sfu_commit_valid
                && !mem_req_valid && !branch_flush && !sim_ebreak) else begin
            $display("valid outputs were not low after reset");
            error_count++;
        end

        test_alu_arith();
        test_branches();
        test_alu_pipeline();
        test_load_store();
        test_sfu();
        test_sim_stop();

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+bench
common/exec_pkg.sv
alu/alu_unit.sv
lsu/lsu_unit.sv
logic/sfu_unit.sv
logic/execute.sv
bench/execute_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= execute_tb
FILELIST  ?= vlog.f
BUILD     ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
